//--- common/cart_pkg.sv
// Cartridge host shared definitions
// Widths, divider phase tables, copier header size and cheat code layout
`default_nettype none

package cart_pkg;

	// ========================================================================
	// Data paths
	// ========================================================================
	localparam int ROM_ADDR_W   = 14;    // 16 KiB store
	localparam int IOCTL_ADDR_W = 16;
	localparam int BYTE_W       = 8;
	localparam int INDEX_W      = 8;     // Download index from the host

	// Copier header prepended by some dump tools
	localparam int HEADER_BYTES = 512;

	// ========================================================================
	// Clock enable divider
	// ========================================================================
	localparam int CE_PERIOD = 30;
	localparam int CE_CNT_W  = $clog2(CE_PERIOD);

	// Counter values on which each enable fires
	localparam logic [5:0][CE_CNT_W-1:0] CE_VDP_PHASES = {
		5'd29, 5'd24, 5'd19, 5'd14, 5'd9, 5'd4
	};
	localparam logic [2:0][CE_CNT_W-1:0] CE_PIX_PHASES = {5'd29, 5'd19, 5'd9};
	localparam logic [1:0][CE_CNT_W-1:0] CE_CPU_PHASES = {5'd24, 5'd9};

	// ========================================================================
	// Cheat codes
	// ========================================================================
	// {flags, address, compare, replace}, 32 bits each, flags on top
	localparam int CHEAT_W     = 128;
	localparam int CHEAT_BYTES = 16;
	localparam int CHEAT_WORDS = 4;

	localparam logic [INDEX_W-1:0] CHEAT_INDEX = '1;

endpackage

`default_nettype wire

//--- logic/clock_enables.sv
// Console clock enable divider
// Counts clk_sys through a thirty-phase cycle and raises the CPU, VDP and
// pixel enables for one cycle on their phase values
`timescale 1ns/1ps
`default_nettype none

module clock_enables (
	input  wire logic clk_sys,
	input  wire logic rst_n,
	output logic      ce_cpu,
	output logic      ce_vdp,
	output logic      ce_pix
);
	import cart_pkg::*;

	logic [CE_CNT_W-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CE_CNT_W'(CE_PERIOD - 1)) begin
			cnt <= '0;           // Wrap after phase 29
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Phase decode
	always_comb begin
		ce_vdp = 1'b0;
		ce_pix = 1'b0;
		ce_cpu = 1'b0;
		for (int i = 0; i < $size(CE_VDP_PHASES); i++) begin
			if (cnt == CE_VDP_PHASES[i]) ce_vdp = 1'b1;   // div 5
		end
		for (int i = 0; i < $size(CE_PIX_PHASES); i++) begin
			if (cnt == CE_PIX_PHASES[i]) ce_pix = 1'b1;   // div 10
		end
		for (int i = 0; i < $size(CE_CPU_PHASES); i++) begin
			if (cnt == CE_CPU_PHASES[i]) ce_cpu = 1'b1;   // div 15, uneven phases
		end
	end

	// The VDP samples every pixel enable, so a pixel tick must land on a VDP tick
	a_pix_on_vdp: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |-> ce_vdp)
		else $error("clock_enables: ce_pix without ce_vdp");

endmodule

`default_nettype wire

//--- cart/cart_loader.sv
// Cartridge loader
// Takes download bytes from the host, holds the host off with ioctl_wait
// while each byte is written to the ROM through a toggle handshake, and
// learns the address masks and copier header flag from the image
`timescale 1ns/1ps
`default_nettype none

module cart_loader (
	input  wire logic                                clk_sys,
	input  wire logic                                rst_n,
	input  wire logic                                cart_download,
	input  wire logic                                ioctl_wr,
	input  wire logic [cart_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  wire logic [cart_pkg::BYTE_W-1:0]         ioctl_dout,
	input  wire logic                                wr_ack,
	output logic                                     ioctl_wait,
	output logic                                     wr_req,
	output logic [cart_pkg::ROM_ADDR_W-1:0]          wr_addr,
	output logic [cart_pkg::BYTE_W-1:0]              wr_data,
	output logic [cart_pkg::ROM_ADDR_W-1:0]          rom_mask,
	output logic [cart_pkg::ROM_ADDR_W-1:0]          rom_mask_hdr,
	output logic                                     has_header,
	output logic                                     console_reset_n
);
	import cart_pkg::*;

	localparam int HDR_BIT = $clog2(HEADER_BYTES);

	logic                  dl_d;
	logic                  byte_wr;
	logic                  wr_done;
	logic [ROM_ADDR_W-1:0] byte_addr;

	assign byte_wr         = ioctl_wr & cart_download;
	assign wr_done         = ioctl_wait && (wr_req == wr_ack);  // Toggles equal again
	assign byte_addr       = ioctl_addr[ROM_ADDR_W-1:0];
	assign console_reset_n = ~cart_download;                    // Hold console during load

	// ========================================================================
	// Write handshake
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_d       <= 1'b0;
			ioctl_wait <= 1'b0;
			wr_req     <= 1'b0;
			wr_addr    <= '0;
		end else begin
			dl_d <= cart_download;

			if (byte_wr) begin
				ioctl_wait <= 1'b1;
				wr_req     <= ~wr_req;      // New request
			end else if (wr_done) begin
				ioctl_wait <= 1'b0;
			end

			if (cart_download && !dl_d) begin
				wr_addr <= '0;              // New image starts at zero
			end else if (wr_done && !byte_wr) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_wr) wr_data <= ioctl_dout;   // Held until acknowledged
	end

	// ========================================================================
	// Mask and header detection
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_mask     <= '1;
			rom_mask_hdr <= '1;
			has_header   <= 1'b0;
		end else begin
			if (byte_wr) begin
				rom_mask     <= (ioctl_addr == '0) ? '0 : (rom_mask | byte_addr);
				rom_mask_hdr <= (ioctl_addr == IOCTL_ADDR_W'(HEADER_BYTES)) ? '0 :
					(rom_mask_hdr | (byte_addr - ROM_ADDR_W'(HEADER_BYTES)));
			end
			// Byte count off by 512 from a power of two means a copier header
			if (dl_d && !cart_download) has_header <= wr_addr[HDR_BIT];
		end
	end

	a_no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wait |-> !ioctl_wr)
		else $error("cart_loader: host strobe while ioctl_wait is high");

endmodule

`default_nettype wire

//--- cart/cart_reader.sv
// Cartridge reader
// Translates console read addresses through the learned mask, skipping the
// copier header when one is present, and returns the ROM data to the console
`timescale 1ns/1ps
`default_nettype none

module cart_reader (
	input  wire logic                           clk_sys,
	input  wire logic                           rst_n,
	input  wire logic                           cons_rd,
	input  wire logic [cart_pkg::ROM_ADDR_W-1:0] cons_addr,
	input  wire logic [cart_pkg::ROM_ADDR_W-1:0] rom_mask,
	input  wire logic [cart_pkg::ROM_ADDR_W-1:0] rom_mask_hdr,
	input  wire logic                           has_header,
	input  wire logic                           rd_valid,
	input  wire logic [cart_pkg::BYTE_W-1:0]     rd_data,
	output logic                                rd_req,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     rd_addr,
	output logic [cart_pkg::BYTE_W-1:0]         cons_data,
	output logic                                cons_valid
);
	import cart_pkg::*;

	logic [ROM_ADDR_W-1:0] phys_addr;

	// Console address to ROM address
	always_comb begin
		if (has_header) begin
			phys_addr = (cons_addr + ROM_ADDR_W'(HEADER_BYTES)) & rom_mask_hdr;
		end else begin
			phys_addr = cons_addr & rom_mask;   // Mirrors small images
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_req <= 1'b0;
		end else begin
			rd_req <= cons_rd;                  // One request per pulse
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cons_rd) rd_addr <= phys_addr;
	end

	// Returned data goes straight back, arbiter keeps the order
	assign cons_valid = rd_valid;
	assign cons_data  = rd_data;

endmodule

`default_nettype wire

//--- cart/rom_arbiter.sv
// ROM port arbiter
// Shares the single ROM port between the console reader and the loader.
// A read present in a cycle always takes the port; a pending write waits
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter (
	input  wire logic                           clk_sys,
	input  wire logic                           rst_n,
	input  wire logic                           rd_req,
	input  wire logic [cart_pkg::ROM_ADDR_W-1:0] rd_addr,
	input  wire logic                           wr_req,
	input  wire logic [cart_pkg::ROM_ADDR_W-1:0] wr_addr,
	input  wire logic [cart_pkg::BYTE_W-1:0]     wr_data,
	input  wire logic [cart_pkg::BYTE_W-1:0]     mem_q,
	output logic                                rd_valid,
	output logic [cart_pkg::BYTE_W-1:0]         rd_data,
	output logic                                wr_ack,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     mem_addr,
	output logic                                mem_we,
	output logic [cart_pkg::BYTE_W-1:0]         mem_d
);

	logic wr_pending;

	assign wr_pending = wr_req ^ wr_ack;    // Toggles differ

	// Port mux, read first
	always_comb begin
		if (rd_req) begin
			mem_addr = rd_addr;
			mem_we   = 1'b0;
		end else begin
			mem_addr = wr_addr;
			mem_we   = wr_pending;
		end
	end

	assign mem_d = wr_data;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ack   <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			if (mem_we) wr_ack <= wr_req;   // Completes the toggle
			rd_valid <= rd_req;             // ROM data lands next cycle
		end
	end

	// Registered ROM output belongs to the read of the previous cycle
	assign rd_data = mem_q;

	// Returned data must come from a cycle in which the port carried a read
	a_read_not_write: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rd_valid |-> $past(rd_req && !mem_we))
		else $error("rom_arbiter: read data from a write cycle");

endmodule

`default_nettype wire

//--- cart/cart_rom.sv
// Cartridge ROM store
// Single-port byte memory with a registered read, written by the loader
// during a download and read by the console afterwards
`timescale 1ns/1ps
`default_nettype none

module cart_rom (
	input  wire logic                           clk_sys,
	input  wire logic [cart_pkg::ROM_ADDR_W-1:0] mem_addr,
	input  wire logic                           mem_we,
	input  wire logic [cart_pkg::BYTE_W-1:0]     mem_d,
	output logic [cart_pkg::BYTE_W-1:0]         mem_q
);
	import cart_pkg::*;

	logic [BYTE_W-1:0] mem [2**ROM_ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_d;
		end
		mem_q <= mem[mem_addr];     // Old data on a write cycle
	end

endmodule

`default_nettype wire

//--- cheat/cheat_loader.sv
// Cheat code loader
// Collects sixteen download bytes into one 128-bit code of flags, address,
// compare and replace words and pulses cheat_valid once the code is whole
`timescale 1ns/1ps
`default_nettype none

module cheat_loader (
	input  wire logic                             clk_sys,
	input  wire logic                             rst_n,
	input  wire logic                             code_download,
	input  wire logic                             ioctl_wr,
	input  wire logic [cart_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  wire logic [cart_pkg::BYTE_W-1:0]       ioctl_dout,
	output logic [cart_pkg::CHEAT_W-1:0]          cheat_code,
	output logic                                  cheat_valid
);
	import cart_pkg::*;

	localparam int IDX_W      = $clog2(CHEAT_BYTES);
	localparam int OFF_W      = $clog2(CHEAT_W);
	localparam int WORD_W     = CHEAT_W / CHEAT_WORDS;
	localparam int WORD_BYTES = WORD_W / BYTE_W;

	logic             code_wr;
	logic [IDX_W-1:0] idx;
	logic [OFF_W-1:0] byte_off;

	assign code_wr = code_download & ioctl_wr;
	assign idx     = ioctl_addr[IDX_W-1:0];

	// First word lands on top, bytes inside a word go in low to high
	assign byte_off = OFF_W'((CHEAT_WORDS - 1 - int'(idx) / WORD_BYTES) * WORD_W
		+ (int'(idx) % WORD_BYTES) * BYTE_W);

	always_ff @(posedge clk_sys) begin
		if (code_wr) cheat_code[byte_off +: BYTE_W] <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (idx == IDX_W'(CHEAT_BYTES - 1));   // Last byte in
		end
	end

endmodule

`default_nettype wire

//--- logic/cart_host.sv
// Cartridge host top level
// Splits host downloads between the cartridge and cheat loaders and connects
// the loader and console reader to the shared ROM through the arbiter.
// Also provides the console clock enables
`timescale 1ns/1ps
`default_nettype none

module cart_host (
	input  wire logic                             clk_sys,
	input  wire logic                             rst_n,
	input  wire logic                             ioctl_download,
	input  wire logic [cart_pkg::INDEX_W-1:0]      ioctl_index,
	input  wire logic                             ioctl_wr,
	input  wire logic [cart_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  wire logic [cart_pkg::BYTE_W-1:0]       ioctl_dout,
	input  wire logic                             cons_rd,
	input  wire logic [cart_pkg::ROM_ADDR_W-1:0]   cons_addr,
	output logic                                  ioctl_wait,
	output logic [cart_pkg::BYTE_W-1:0]           cons_data,
	output logic                                  cons_valid,
	output logic [cart_pkg::CHEAT_W-1:0]          cheat_code,
	output logic                                  cheat_valid,
	output logic                                  ce_cpu,
	output logic                                  ce_vdp,
	output logic                                  ce_pix,
	output logic                                  console_reset_n
);
	import cart_pkg::*;

	logic                  code_download;
	logic                  cart_download;
	logic                  wr_req, wr_ack;
	logic [ROM_ADDR_W-1:0] wr_addr;
	logic [BYTE_W-1:0]     wr_data;
	logic [ROM_ADDR_W-1:0] rom_mask, rom_mask_hdr;
	logic                  has_header;
	logic                  rd_req, rd_valid;
	logic [ROM_ADDR_W-1:0] rd_addr;
	logic [BYTE_W-1:0]     rd_data;
	logic [ROM_ADDR_W-1:0] mem_addr;
	logic                  mem_we;
	logic [BYTE_W-1:0]     mem_d, mem_q;

	// Index decode
	assign code_download = ioctl_download & (ioctl_index == CHEAT_INDEX);
	assign cart_download = ioctl_download & (ioctl_index != CHEAT_INDEX);

	clock_enables u_clock_enables (
		.clk_sys (clk_sys), .rst_n (rst_n),
		.ce_cpu  (ce_cpu),  .ce_vdp (ce_vdp), .ce_pix (ce_pix)
	);

	cart_loader u_cart_loader (
		.clk_sys       (clk_sys),       .rst_n           (rst_n),
		.cart_download (cart_download), .ioctl_wr        (ioctl_wr),
		.ioctl_addr    (ioctl_addr),    .ioctl_dout      (ioctl_dout),
		.wr_ack        (wr_ack),        .ioctl_wait      (ioctl_wait),
		.wr_req        (wr_req),        .wr_addr         (wr_addr),
		.wr_data       (wr_data),       .rom_mask        (rom_mask),
		.rom_mask_hdr  (rom_mask_hdr),  .has_header      (has_header),
		.console_reset_n (console_reset_n)
	);

	cart_reader u_cart_reader (
		.clk_sys    (clk_sys),    .rst_n        (rst_n),
		.cons_rd    (cons_rd),    .cons_addr    (cons_addr),
		.rom_mask   (rom_mask),   .rom_mask_hdr (rom_mask_hdr),
		.has_header (has_header), .rd_valid     (rd_valid),
		.rd_data    (rd_data),    .rd_req       (rd_req),
		.rd_addr    (rd_addr),    .cons_data    (cons_data),
		.cons_valid (cons_valid)
	);

	rom_arbiter u_rom_arbiter (
		.clk_sys  (clk_sys),  .rst_n   (rst_n),
		.rd_req   (rd_req),   .rd_addr (rd_addr),
		.wr_req   (wr_req),   .wr_addr (wr_addr),
		.wr_data  (wr_data),  .mem_q   (mem_q),
		.rd_valid (rd_valid), .rd_data (rd_data),
		.wr_ack   (wr_ack),   .mem_addr (mem_addr),
		.mem_we   (mem_we),   .mem_d   (mem_d)
	);

	cart_rom u_cart_rom (
		.clk_sys (clk_sys), .mem_addr (mem_addr),
		.mem_we  (mem_we),  .mem_d    (mem_d), .mem_q (mem_q)
	);

	cheat_loader u_cheat_loader (
		.clk_sys       (clk_sys),       .rst_n      (rst_n),
		.code_download (code_download), .ioctl_wr   (ioctl_wr),
		.ioctl_addr    (ioctl_addr),    .ioctl_dout (ioctl_dout),
		.cheat_code    (cheat_code),    .cheat_valid (cheat_valid)
	);

endmodule

`default_nettype wire

//--- tb/tb_cases.svh
// Case table for the cartridge host testbench
// Columns are operation, address, data and expected value
//   OP_CE     window cycles, ce_cpu gap, {vdp, pix, cpu} pulse counts
//   OP_LOAD   image size, console reads alongside, bytes accepted
//   OP_READ   console address, unused, image index of the expected byte
//   OP_READ2  {second, first} address, unused, {second, first} image index
//   OP_CHEAT  unused, first cheat byte, cheat_valid pulses
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

localparam int NUM_CASES = 16;

localparam case_t CASES [NUM_CASES] = '{
	'{OP_CE,    60,            15,     32'h000C_0604},
	'{OP_LOAD,  4096,          1,      4096},
	'{OP_READ,  0,             0,      0},
	'{OP_READ,  1234,          0,      1234},
	'{OP_READ,  4095,          0,      4095},
	'{OP_READ,  5330,          0,      1234},           // Mirror of 1234
	'{OP_READ,  12295,         0,      7},
	'{OP_READ2, 32'h100B_000A, 0,      32'h000B_000A},
	// 512 byte header in front of a 4 KiB image
	'{OP_LOAD,  4608,          1,      4608},
	'{OP_READ,  0,             0,      512},
	'{OP_READ,  3583,          0,      4095},
	'{OP_READ,  3584,          0,      0},              // Wraps to the header
	'{OP_READ,  4000,          0,      416},
	'{OP_READ,  8202,          0,      522},
	'{OP_READ2, 32'h0E10_0064, 0,      32'h0010_0264},
	'{OP_CHEAT, 0,             32'h3C, 1}
};

`endif

//--- tb/tb_cart_host.sv
// Cartridge host testbench
// Applies a table of divider, download, console read and cheat cases to the
// top level and checks the DUT against a reference copy of each image
`timescale 1ns/1ps
`default_nettype none

module tb_cart_host;
	import cart_pkg::*;

	localparam int OP_CE    = 0;
	localparam int OP_LOAD  = 1;
	localparam int OP_READ  = 2;
	localparam int OP_READ2 = 3;   // Two reads back to back
	localparam int OP_CHEAT = 4;

	typedef struct packed {
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
	} case_t;

	`include "tb_cases.svh"

	logic                    clk_sys, rst_n;
	logic                    ioctl_download, ioctl_wr;
	logic [INDEX_W-1:0]      ioctl_index;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [BYTE_W-1:0]       ioctl_dout;
	logic                    cons_rd;
	logic [ROM_ADDR_W-1:0]   cons_addr;
	logic                    ioctl_wait, cons_valid, cheat_valid;
	logic [BYTE_W-1:0]       cons_data;
	logic [CHEAT_W-1:0]      cheat_code;
	logic                    ce_cpu, ce_vdp, ce_pix, console_reset_n;

	logic [BYTE_W-1:0] img [2**IOCTL_ADDR_W];   // Reference image
	int                errors, row_errors;

	cart_host u_cart_host (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s got %0h exp %0h", $time, name, got, exp);
			row_errors++;
		end
	endtask

	task automatic report_error(input string what);
		$display("ERROR t=%0t %s", $time, what);
		row_errors++;
	endtask

	task automatic drive_noise(input logic on);
		cons_rd   = on & 1'($urandom);
		cons_addr = ROM_ADDR_W'($urandom);
	endtask

	// ========================================================================
	// Case tasks
	// ========================================================================
	task automatic count_enables(input int cycles, input int gap, input logic [31:0] exp);
		int n_vdp, n_pix, n_cpu, last_cpu;
		n_vdp    = 0;
		n_pix    = 0;
		n_cpu    = 0;
		last_cpu = -1;
		for (int c = 0; c < cycles; c++) begin
			next_cycle();
			if (ce_vdp) n_vdp++;
			if (ce_pix) n_pix++;
			if (ce_cpu) begin
				n_cpu++;
				if (last_cpu >= 0) check("ce_cpu spacing", c - last_cpu, gap);
				last_cpu = c;
			end
		end
		check("ce_vdp pulses", n_vdp, 32'(exp[23:16]));
		check("ce_pix pulses", n_pix, 32'(exp[15:8]));
		check("ce_cpu pulses", n_cpu, 32'(exp[7:0]));
	endtask

	task automatic download(input int size, input logic noise, input int exp_count);
		int accepted;
		int n;
		for (int i = 0; i < size; i++) img[i] = BYTE_W'($urandom);
		ioctl_download = 1'b1;
		ioctl_index    = '0;
		drive_noise(noise);
		next_cycle();
		accepted = 0;
		for (int i = 0; i < size && row_errors == 0; i++) begin
			ioctl_wr   = 1'b1;
			ioctl_addr = IOCTL_ADDR_W'(i);
			ioctl_dout = img[i];
			drive_noise(noise);
			next_cycle();
			ioctl_wr = 1'b0;
			check("ioctl_wait", 32'(ioctl_wait), 1);
			check("console_reset_n", 32'(console_reset_n), 0);
			n = 0;
			while (ioctl_wait && n < 64) begin
				drive_noise(noise);
				next_cycle();
				n++;
			end
			if (ioctl_wait) report_error("ioctl_wait stuck high after a download strobe");
			else accepted++;
		end
		cons_rd        = 1'b0;
		ioctl_download = 1'b0;
		next_cycle();
		next_cycle();   // Let reads still in flight drain
		check("bytes accepted", accepted, exp_count);
		check("console_reset_n", 32'(console_reset_n), 1);
	endtask

	task automatic console_read(input logic [ROM_ADDR_W-1:0] addr,
		output logic [BYTE_W-1:0] data, output int lat);
		cons_rd   = 1'b1;
		cons_addr = addr;
		next_cycle();
		cons_rd = 1'b0;
		lat     = 1;
		while (!cons_valid && lat < 16) begin
			next_cycle();
			lat++;
		end
		data = cons_data;
	endtask

	task automatic read_pair(input logic [31:0] addrs, input logic [31:0] idxs);
		cons_rd   = 1'b1;
		cons_addr = ROM_ADDR_W'(addrs[15:0]);
		next_cycle();
		cons_addr = ROM_ADDR_W'(addrs[31:16]);
		next_cycle();
		cons_rd = 1'b0;
		check("cons_valid first", 32'(cons_valid), 1);
		check("cons_data first", 32'(cons_data), 32'(img[idxs[15:0]]));
		next_cycle();
		check("cons_valid second", 32'(cons_valid), 1);
		check("cons_data second", 32'(cons_data), 32'(img[idxs[31:16]]));
		next_cycle();
		check("cons_valid after pair", 32'(cons_valid), 0);
	endtask

	task automatic cheat_download(input logic [BYTE_W-1:0] base, input int exp_pulses);
		logic [CHEAT_W-1:0] exp_code;
		logic [BYTE_W-1:0]  code_bytes [CHEAT_BYTES];
		logic [31:0]        words [4];   // Flags, address, compare, replace
		int                 pulses;
		ioctl_download = 1'b1;
		ioctl_index    = CHEAT_INDEX;
		next_cycle();
		pulses = 0;
		for (int n = 0; n < CHEAT_BYTES; n++) begin
			code_bytes[n] = base + 8'(n * 17);
			ioctl_wr   = 1'b1;
			ioctl_addr = IOCTL_ADDR_W'(n);
			ioctl_dout = code_bytes[n];
			next_cycle();
			if (cheat_valid) pulses++;
		end
		ioctl_wr = 1'b0;
		for (int c = 0; c < 4; c++) begin
			next_cycle();
			if (cheat_valid) pulses++;
		end
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		// First byte of each word in the low bits
		for (int w = 0; w < 4; w++) begin
			words[w] = {code_bytes[4*w+3], code_bytes[4*w+2],
				code_bytes[4*w+1], code_bytes[4*w]};
		end
		exp_code = {words[0], words[1], words[2], words[3]};   // Flags word on top
		check("cheat_valid pulses", pulses, exp_pulses);
		assert (cheat_code === exp_code) else begin
			$display("MISMATCH t=%0t cheat_code got %h exp %h", $time, cheat_code, exp_code);
			row_errors++;
		end
	endtask

	// ========================================================================
	// Watchdog and main sequence
	// ========================================================================
	initial begin
		int budget;
		budget = 200;
		for (int i = 0; i < NUM_CASES; i++) begin
			budget += (int'(CASES[i].op) == OP_LOAD) ? int'(CASES[i].addr) * 16 : 40;
		end
		repeat (budget) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the run did not finish", budget);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int                failed_rows;
		int                lat;
		logic [BYTE_W-1:0] got;
		void'($urandom(67));
		errors         = 0;
		failed_rows    = 0;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		cons_rd        = 1'b0;
		cons_addr      = '0;
		repeat (5) @(posedge clk_sys);
		#1 rst_n = 1'b1;

		for (int i = 0; i < NUM_CASES; i++) begin
			row_errors = 0;
			case (int'(CASES[i].op))
				OP_CE:    count_enables(int'(CASES[i].addr), int'(CASES[i].data), CASES[i].exp);
				OP_LOAD:  download(int'(CASES[i].addr), CASES[i].data[0], int'(CASES[i].exp));
				OP_READ: begin
					console_read(ROM_ADDR_W'(CASES[i].addr), got, lat);
					check("cons_valid latency", lat, 2);
					check("cons_data", 32'(got), 32'(img[CASES[i].exp[15:0]]));
				end
				OP_READ2: read_pair(CASES[i].addr, CASES[i].exp);
				OP_CHEAT: cheat_download(CASES[i].data[7:0], int'(CASES[i].exp));
				default:  report_error("unknown operation in the case table");
			endcase
			$display("case %0d op %0d %s", i, CASES[i].op, (row_errors == 0) ? "passed" : "failed");
			errors += row_errors;
			if (row_errors != 0) failed_rows++;
		end

		$display("%0d cases run, %0d failed, %0d checks failed", NUM_CASES, failed_rows, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+tb
common/cart_pkg.sv
logic/clock_enables.sv
cart/cart_loader.sv
cart/cart_reader.sv
cart/rom_arbiter.sv
cart/cart_rom.sv
cheat/cheat_loader.sv
logic/cart_host.sv
tb/tb_cart_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the cartridge host testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_cart_host \
	-Mdir obj_dir > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_cart_host > sim.log 2>&1 ; cat sim.log

grep -qx "Test OK" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
